// ==== hdl/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

    localparam int wordSize = 16;

    // Opcodes in instruction bits [15:12]
    localparam logic [3:0] opBne = 4'd0;
    localparam logic [3:0] opBeq = 4'd1;
    localparam logic [3:0] opAdi = 4'd4;
    localparam logic [3:0] opLhi = 4'd6;
    localparam logic [3:0] opLwd = 4'd7;
    localparam logic [3:0] opSwd = 4'd8;
    localparam logic [3:0] opJmp = 4'd9;
    localparam logic [3:0] opRType = 4'd15;

    // R-type function field, bits [5:0]
    localparam logic [5:0] funcAdd = 6'd0;
    localparam logic [5:0] funcSub = 6'd1;
    localparam logic [5:0] funcAnd = 6'd2;
    localparam logic [5:0] funcOrr = 6'd3;
    localparam logic [5:0] funcWwd = 6'd28;
    localparam logic [5:0] funcHlt = 6'd29;

    localparam int ctrlWidth = 10;

    // Writeback group
    localparam int ctlWwd = 0;
    localparam int ctlRegWrite = 1;
    localparam int ctlMemToReg = 2;
    localparam int ctlHalt = 3;
    // Memory group
    localparam int ctlMemWrite = 4;
    localparam int ctlMemRead = 5;
    // Execute group
    localparam int ctlIsBranch = 6;
    localparam int ctlAluSrc = 7;
    localparam int ctlIsAlu = 8;
    localparam int ctlIsJump = 9;

    // Operand source for execute
    localparam logic [1:0] fwdNone = 2'd0;
    localparam logic [1:0] fwdMem = 2'd1;
    localparam logic [1:0] fwdWb = 2'd2;

endpackage

`default_nettype wire

// ==== hdl/controlUnit.sv ====
`default_nettype none

module controlUnit (
    input  wire [cpuPkg::wordSize-1:0]   instruction,
    output logic [cpuPkg::ctrlWidth-1:0] controls
);

    logic [3:0] opcode;
    logic [5:0] func;

    assign opcode = instruction[15:12];
    assign func = instruction[5:0];

    always_comb begin
        controls = '0;
        case (opcode)
            cpuPkg::opRType: begin
                case (func)
                    cpuPkg::funcAdd, cpuPkg::funcSub, cpuPkg::funcAnd, cpuPkg::funcOrr: begin
                        controls[cpuPkg::ctlRegWrite] = 1'b1;
                        controls[cpuPkg::ctlIsAlu] = 1'b1;
                    end
                    cpuPkg::funcWwd: begin
                        // rs goes through the ALU unchanged
                        controls[cpuPkg::ctlWwd] = 1'b1;
                        controls[cpuPkg::ctlIsAlu] = 1'b1;
                    end
                    cpuPkg::funcHlt: begin
                        controls[cpuPkg::ctlHalt] = 1'b1;
                    end
                    default: controls = '0;
                endcase
            end
            cpuPkg::opAdi: begin
                controls[cpuPkg::ctlRegWrite] = 1'b1;
                controls[cpuPkg::ctlAluSrc] = 1'b1;
                controls[cpuPkg::ctlIsAlu] = 1'b1;
            end
            cpuPkg::opLhi: begin
                controls[cpuPkg::ctlRegWrite] = 1'b1;
            end
            cpuPkg::opLwd: begin
                controls[cpuPkg::ctlRegWrite] = 1'b1;
                controls[cpuPkg::ctlMemToReg] = 1'b1;
                controls[cpuPkg::ctlMemRead] = 1'b1;
                controls[cpuPkg::ctlAluSrc] = 1'b1;
                controls[cpuPkg::ctlIsAlu] = 1'b1;
            end
            cpuPkg::opSwd: begin
                controls[cpuPkg::ctlMemWrite] = 1'b1;
                controls[cpuPkg::ctlAluSrc] = 1'b1;
                controls[cpuPkg::ctlIsAlu] = 1'b1;
            end
            cpuPkg::opBne, cpuPkg::opBeq: begin
                controls[cpuPkg::ctlIsBranch] = 1'b1;
                controls[cpuPkg::ctlIsAlu] = 1'b1;
            end
            cpuPkg::opJmp: begin
                controls[cpuPkg::ctlIsJump] = 1'b1;
            end
            default: controls = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/registerFile.sv ====
`default_nettype none

module registerFile (
    input  wire                         Clk,
    input  wire                         arstN,
    input  wire [1:0]                   readAddr1,
    input  wire [1:0]                   readAddr2,
    input  wire [1:0]                   writeAddr,
    input  wire [cpuPkg::wordSize-1:0]  writeData,
    input  wire                         writeEnable,
    output logic [cpuPkg::wordSize-1:0] readData1,
    output logic [cpuPkg::wordSize-1:0] readData2
);

    logic [cpuPkg::wordSize-1:0] regs [4];

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Writeback value bypasses to decode in the same cycle
    assign readData1 = (writeEnable && writeAddr == readAddr1) ? writeData : regs[readAddr1];
    assign readData2 = (writeEnable && writeAddr == readAddr2) ? writeData : regs[readAddr2];

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`default_nettype none

module alu (
    input  wire [3:0]                   opcode,
    input  wire [5:0]                   func,
    input  wire [cpuPkg::wordSize-1:0]  operandA,
    input  wire [cpuPkg::wordSize-1:0]  operandB,
    output logic [cpuPkg::wordSize-1:0] result,
    output logic                        branchTaken
);

    logic equal;

    assign equal = (operandA == operandB);

    always_comb begin
        case (opcode)
            // Address and immediate add
            cpuPkg::opAdi, cpuPkg::opLwd, cpuPkg::opSwd: result = operandA + operandB;
            cpuPkg::opRType: begin
                case (func)
                    cpuPkg::funcAdd: result = operandA + operandB;
                    cpuPkg::funcSub: result = operandA - operandB;
                    cpuPkg::funcAnd: result = operandA & operandB;
                    cpuPkg::funcOrr: result = operandA | operandB;
                    cpuPkg::funcWwd: result = operandA;
                    default: result = '0;
                endcase
            end
            default: result = '0;
        endcase
    end

    always_comb begin
        case (opcode)
            cpuPkg::opBne: branchTaken = !equal;
            cpuPkg::opBeq: branchTaken = equal;
            default: branchTaken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/hazardUnit.sv ====
`default_nettype none

module hazardUnit (
    input  wire [1:0]  decodeRs,
    input  wire [1:0]  decodeRt,
    input  wire        decodeUsesRs,
    input  wire        decodeUsesRt,
    input  wire [1:0]  execRs,
    input  wire [1:0]  execRt,
    input  wire [1:0]  execRd,
    input  wire        execMemRead,
    input  wire [1:0]  memRd,
    input  wire        memRegWrite,
    input  wire [1:0]  wbRd,
    input  wire        wbRegWrite,
    output logic [1:0] forwardA,
    output logic [1:0] forwardB,
    output logic       stall
);

    // Memory stage holds the newer value, so it wins
    always_comb begin
        if (memRegWrite && memRd == execRs) begin
            forwardA = cpuPkg::fwdMem;
        end else if (wbRegWrite && wbRd == execRs) begin
            forwardA = cpuPkg::fwdWb;
        end else begin
            forwardA = cpuPkg::fwdNone;
        end

        if (memRegWrite && memRd == execRt) begin
            forwardB = cpuPkg::fwdMem;
        end else if (wbRegWrite && wbRd == execRt) begin
            forwardB = cpuPkg::fwdWb;
        end else begin
            forwardB = cpuPkg::fwdNone;
        end
    end

    // Load data is not ready until writeback
    assign stall = execMemRead &&
                   ((decodeUsesRs && decodeRs == execRd) || (decodeUsesRt && decodeRt == execRd));

endmodule

`default_nettype wire

// ==== hdl/datapath.sv ====
`default_nettype none

module datapath #(
    parameter logic [cpuPkg::wordSize-1:0] resetPc = '0
) (
    input  wire                          Clk,
    input  wire                          arstN,
    input  wire [cpuPkg::ctrlWidth-1:0]  controls,
    output logic [cpuPkg::wordSize-1:0]  fetchedInstr,
    output logic                         readM1,
    output logic [cpuPkg::wordSize-1:0]  address1,
    input  wire [cpuPkg::wordSize-1:0]   data1,
    output logic                         readM2,
    output logic                         writeM2,
    output logic [cpuPkg::wordSize-1:0]  address2,
    output logic [cpuPkg::wordSize-1:0]  writeData2,
    input  wire [cpuPkg::wordSize-1:0]   readData2,
    output logic [cpuPkg::wordSize-1:0]  outputPort,
    output logic                         wwdStrobe,
    output logic [cpuPkg::wordSize-1:0]  numInst,
    output logic                         isHalted
);

    localparam int dw = cpuPkg::wordSize;

    logic [dw-1:0] pc;

    logic ifidBubble;
    logic [dw-1:0] ifidPc;
    logic [dw-1:0] ifidInstr;

    logic idexBubble;
    logic [cpuPkg::ctrlWidth-1:0] idexCtl;
    logic [dw-1:0] idexPc;
    logic [dw-1:0] idexInstr;
    logic [dw-1:0] idexRsData;
    logic [dw-1:0] idexRtData;
    logic [1:0] idexRd;

    logic exmemBubble;
    logic [cpuPkg::ctrlWidth-1:0] exmemCtl;
    logic [dw-1:0] exmemResult;
    logic [dw-1:0] exmemStoreData;
    logic [1:0] exmemRd;

    logic memwbBubble;
    logic [cpuPkg::ctrlWidth-1:0] memwbCtl;
    logic [dw-1:0] memwbResult;
    logic [dw-1:0] memwbMemData;
    logic [1:0] memwbRd;

    logic [3:0] idOpcode;
    logic [5:0] idFunc;
    logic idIsRType;
    logic usesRs;
    logic usesRt;
    logic [1:0] idDest;
    logic [dw-1:0] rsData;
    logic [dw-1:0] rtData;

    logic [dw-1:0] exImm;
    logic [1:0] forwardA;
    logic [1:0] forwardB;
    logic [dw-1:0] fwdRs;
    logic [dw-1:0] fwdRt;
    logic [dw-1:0] aluB;
    logic [dw-1:0] aluResult;
    logic [dw-1:0] exResult;
    logic [dw-1:0] branchTarget;
    logic [dw-1:0] jumpTarget;
    logic branchTaken;
    logic flush;
    logic drain;
    logic stall;
    logic [dw-1:0] wbData;

    // Decode
    assign idOpcode = ifidInstr[15:12];
    assign idFunc = ifidInstr[5:0];
    assign idIsRType = (idOpcode == cpuPkg::opRType);
    assign idDest = idIsRType ? ifidInstr[7:6] : ifidInstr[9:8];
    assign usesRs = !ifidBubble && idOpcode != cpuPkg::opJmp && idOpcode != cpuPkg::opLhi &&
                    !(idIsRType && idFunc == cpuPkg::funcHlt);
    assign usesRt = !ifidBubble &&
                    (idOpcode inside {cpuPkg::opSwd, cpuPkg::opBne, cpuPkg::opBeq} ||
                     (idIsRType && idFunc inside {cpuPkg::funcAdd, cpuPkg::funcSub,
                                                  cpuPkg::funcAnd, cpuPkg::funcOrr}));

    registerFile uRegs (
        .Clk        (Clk),
        .arstN      (arstN),
        .readAddr1  (ifidInstr[11:10]),
        .readAddr2  (ifidInstr[9:8]),
        .writeAddr  (memwbRd),
        .writeData  (wbData),
        .writeEnable(memwbCtl[cpuPkg::ctlRegWrite]),
        .readData1  (rsData),
        .readData2  (rtData)
    );

    hazardUnit uHazard (
        .decodeRs    (ifidInstr[11:10]),
        .decodeRt    (ifidInstr[9:8]),
        .decodeUsesRs(usesRs),
        .decodeUsesRt(usesRt),
        .execRs      (idexInstr[11:10]),
        .execRt      (idexInstr[9:8]),
        .execRd      (idexRd),
        .execMemRead (idexCtl[cpuPkg::ctlMemRead]),
        .memRd       (exmemRd),
        .memRegWrite (exmemCtl[cpuPkg::ctlRegWrite]),
        .wbRd        (memwbRd),
        .wbRegWrite  (memwbCtl[cpuPkg::ctlRegWrite]),
        .forwardA    (forwardA),
        .forwardB    (forwardB),
        .stall       (stall)
    );

    // Execute
    assign exImm = {{(dw - 8){idexInstr[7]}}, idexInstr[7:0]};
    assign fwdRs = (forwardA == cpuPkg::fwdMem) ? exmemResult :
                   (forwardA == cpuPkg::fwdWb) ? wbData : idexRsData;
    assign fwdRt = (forwardB == cpuPkg::fwdMem) ? exmemResult :
                   (forwardB == cpuPkg::fwdWb) ? wbData : idexRtData;
    assign aluB = idexCtl[cpuPkg::ctlAluSrc] ? exImm : fwdRt;

    alu uAlu (
        .opcode     (idexInstr[15:12]),
        .func       (idexInstr[5:0]),
        .operandA   (fwdRs),
        .operandB   (aluB),
        .result     (aluResult),
        .branchTaken(branchTaken)
    );

    // LHI is the only writer that bypasses the ALU
    assign exResult = idexCtl[cpuPkg::ctlIsAlu] ? aluResult : {idexInstr[7:0], 8'h00};
    assign branchTarget = idexPc + dw'(1) + exImm;
    assign jumpTarget = {idexPc[dw-1:12], idexInstr[11:0]};
    assign flush = idexCtl[cpuPkg::ctlIsJump] || (idexCtl[cpuPkg::ctlIsBranch] && branchTaken);
    // Nothing behind a HLT may proceed
    assign drain = idexCtl[cpuPkg::ctlHalt] || exmemCtl[cpuPkg::ctlHalt] ||
                   memwbCtl[cpuPkg::ctlHalt];

    assign wbData = memwbCtl[cpuPkg::ctlMemToReg] ? memwbMemData : memwbResult;

    assign readM1 = !isHalted;
    assign address1 = pc;
    assign fetchedInstr = ifidInstr;
    assign readM2 = exmemCtl[cpuPkg::ctlMemRead];
    assign writeM2 = exmemCtl[cpuPkg::ctlMemWrite];
    assign address2 = exmemResult;
    assign writeData2 = exmemStoreData;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            pc <= resetPc;
            ifidBubble <= 1'b1;
            idexBubble <= 1'b1;
            exmemBubble <= 1'b1;
            memwbBubble <= 1'b1;
            idexCtl <= '0;
            exmemCtl <= '0;
            memwbCtl <= '0;
            numInst <= '0;
            outputPort <= '0;
            wwdStrobe <= 1'b0;
            isHalted <= 1'b0;
        end else if (!isHalted) begin
            if (flush) begin
                pc <= idexCtl[cpuPkg::ctlIsJump] ? jumpTarget : branchTarget;
            end else if (!drain && !stall) begin
                pc <= pc + dw'(1);
            end

            if (flush || drain) begin
                ifidBubble <= 1'b1;
            end else if (!stall) begin
                ifidBubble <= 1'b0;
            end

            if (ifidBubble || stall || flush || drain) begin
                idexBubble <= 1'b1;
                idexCtl <= '0;
            end else begin
                idexBubble <= 1'b0;
                idexCtl <= controls;
            end

            exmemBubble <= idexBubble;
            exmemCtl <= idexCtl;
            memwbBubble <= exmemBubble;
            memwbCtl <= exmemCtl;

            // Retire
            wwdStrobe <= !memwbBubble && memwbCtl[cpuPkg::ctlWwd];
            if (!memwbBubble) begin
                numInst <= numInst + dw'(1);
                if (memwbCtl[cpuPkg::ctlWwd]) begin
                    outputPort <= memwbResult;
                end
                if (memwbCtl[cpuPkg::ctlHalt]) begin
                    isHalted <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (!isHalted) begin
            if (!stall) begin
                ifidPc <= pc;
                ifidInstr <= data1;
            end
            idexPc <= ifidPc;
            idexInstr <= ifidInstr;
            idexRsData <= rsData;
            idexRtData <= rtData;
            idexRd <= idDest;
            exmemResult <= exResult;
            exmemStoreData <= fwdRt;
            exmemRd <= idexRd;
            memwbResult <= exmemResult;
            memwbMemData <= readData2;
            memwbRd <= exmemRd;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cpuTop.sv ====
`default_nettype none

module cpuTop #(
    parameter logic [cpuPkg::wordSize-1:0] resetPc = '0
) (
    input  wire                          Clk,
    input  wire                          arstN,
    output logic                         readM1,
    output logic [cpuPkg::wordSize-1:0]  address1,
    input  wire [cpuPkg::wordSize-1:0]   data1,
    output logic                         readM2,
    output logic                         writeM2,
    output logic [cpuPkg::wordSize-1:0]  address2,
    output logic [cpuPkg::wordSize-1:0]  writeData2,
    input  wire [cpuPkg::wordSize-1:0]   readData2,
    output logic [cpuPkg::wordSize-1:0]  outputPort,
    output logic                         wwdStrobe,
    output logic [cpuPkg::wordSize-1:0]  numInst,
    output logic                         isHalted
);

    logic [cpuPkg::wordSize-1:0] fetchedInstr;
    logic [cpuPkg::ctrlWidth-1:0] controls;

    controlUnit uControl (
        .instruction(fetchedInstr),
        .controls   (controls)
    );

    datapath #(
        .resetPc(resetPc)
    ) uDatapath (
        .Clk         (Clk),
        .arstN       (arstN),
        .controls    (controls),
        .fetchedInstr(fetchedInstr),
        .readM1      (readM1),
        .address1    (address1),
        .data1       (data1),
        .readM2      (readM2),
        .writeM2     (writeM2),
        .address2    (address2),
        .writeData2  (writeData2),
        .readData2   (readData2),
        .outputPort  (outputPort),
        .wwdStrobe   (wwdStrobe),
        .numInst     (numInst),
        .isHalted    (isHalted)
    );

endmodule

`default_nettype wire

// ==== testbench/cpu_checker.sv ====
`default_nettype none

module cpuChecker (
    input wire        Clk,
    input wire        arstN,
    input wire        readM1,
    input wire        readM2,
    input wire        writeM2,
    input wire        wwdStrobe,
    input wire [15:0] numInst,
    input wire        isHalted
);

    // One data access per cycle
    noReadWrite: assert property (
        @(posedge Clk) disable iff (!arstN) !(readM2 && writeM2)
    ) else $error("readM2 and writeM2 high together");

    haltSticky: assert property (
        @(posedge Clk) disable iff (!arstN) isHalted |=> isHalted
    ) else $error("isHalted dropped without reset");

    noFetchHalted: assert property (
        @(posedge Clk) disable iff (!arstN) isHalted |-> !readM1
    ) else $error("readM1 high while halted");

    strobeOneCycle: assert property (
        @(posedge Clk) disable iff (!arstN) wwdStrobe |=> !wwdStrobe
    ) else $error("wwdStrobe longer than one cycle");

    retireRate: assert property (
        @(posedge Clk) disable iff (!arstN)
        (numInst == $past(numInst)) || (numInst == $past(numInst) + 16'd1)
    ) else $error("numInst moved by more than one");

endmodule

bind cpuTop cpuChecker uChecker (
    .Clk      (Clk),
    .arstN    (arstN),
    .readM1   (readM1),
    .readM2   (readM2),
    .writeM2  (writeM2),
    .wwdStrobe(wwdStrobe),
    .numInst  (numInst),
    .isHalted (isHalted)
);

`default_nettype wire

// ==== testbench/cpuTb.sv ====
`default_nettype none

module cpuTb;

    localparam int numExpected = 7;
    localparam logic [15:0] expectedRetired = 16'd24;
    localparam int haltTimeout = 300;

    logic Clk;
    logic arstN;
    logic readM1;
    logic [15:0] address1;
    logic [15:0] data1;
    logic readM2;
    logic writeM2;
    logic [15:0] address2;
    logic [15:0] writeData2;
    logic [15:0] readData2;
    logic [15:0] outputPort;
    logic wwdStrobe;
    logic [15:0] numInst;
    logic isHalted;

    logic [15:0] instrMem [256];
    logic [15:0] dataMem [256];
    logic [15:0] expected [numExpected];
    int strobeCount;

    cpuTop #(
        .resetPc(16'h0000)
    ) UUT (
        .Clk       (Clk),
        .arstN     (arstN),
        .readM1    (readM1),
        .address1  (address1),
        .data1     (data1),
        .readM2    (readM2),
        .writeM2   (writeM2),
        .address2  (address2),
        .writeData2(writeData2),
        .readData2 (readData2),
        .outputPort(outputPort),
        .wwdStrobe (wwdStrobe),
        .numInst   (numInst),
        .isHalted  (isHalted)
    );

    always #10 Clk = ~Clk;

    // Both memories read combinationally, and only while strobed
    assign data1 = readM1 ? instrMem[address1[7:0]] : '0;
    assign readData2 = readM2 ? dataMem[address2[7:0]] : '0;

    always @(posedge Clk) begin
        if (writeM2) begin
            dataMem[address2[7:0]] <= writeData2;
        end
    end

    function automatic logic [15:0] rType(input logic [1:0] rs, input logic [1:0] rt,
                                          input logic [1:0] rd, input logic [5:0] func);
        return {cpuPkg::opRType, rs, rt, rd, func};
    endfunction

    function automatic logic [15:0] iType(input logic [3:0] op, input logic [1:0] rs,
                                          input logic [1:0] rt, input logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [15:0] wwd(input logic [1:0] rs);
        return rType(rs, 2'd0, 2'd0, cpuPkg::funcWwd);
    endfunction

    task automatic stopRun;
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic loadProgram;
        for (int i = 0; i < 256; i++) begin
            // Unused slots would strobe if ever executed
            instrMem[i] = wwd(2'd0);
            dataMem[i] = 16'($urandom());
        end
        instrMem[0] = iType(cpuPkg::opLhi, 2'd0, 2'd1, 8'h12);
        instrMem[1] = iType(cpuPkg::opAdi, 2'd1, 2'd1, 8'h34);
        instrMem[2] = iType(cpuPkg::opAdi, 2'd0, 2'd2, 8'h05);
        instrMem[3] = rType(2'd1, 2'd2, 2'd3, cpuPkg::funcAdd);
        instrMem[4] = wwd(2'd3);
        instrMem[5] = rType(2'd3, 2'd2, 2'd3, cpuPkg::funcSub);
        instrMem[6] = rType(2'd3, 2'd2, 2'd0, cpuPkg::funcAnd);
        instrMem[7] = wwd(2'd0);
        instrMem[8] = rType(2'd3, 2'd2, 2'd3, cpuPkg::funcOrr);
        instrMem[9] = wwd(2'd3);
        // Store, reload and use at once
        instrMem[10] = iType(cpuPkg::opAdi, 2'd0, 2'd0, 8'h10);
        instrMem[11] = iType(cpuPkg::opSwd, 2'd0, 2'd3, 8'h00);
        instrMem[12] = iType(cpuPkg::opLwd, 2'd0, 2'd1, 8'h00);
        instrMem[13] = rType(2'd1, 2'd2, 2'd2, cpuPkg::funcAdd);
        instrMem[14] = wwd(2'd2);
        instrMem[15] = iType(cpuPkg::opBne, 2'd2, 2'd2, 8'd2);
        instrMem[16] = wwd(2'd1);
        instrMem[17] = iType(cpuPkg::opBeq, 2'd1, 2'd1, 8'd2);
        instrMem[18] = wwd(2'd0);
        instrMem[19] = wwd(2'd0);
        instrMem[20] = iType(cpuPkg::opAdi, 2'd1, 2'd1, 8'h01);
        instrMem[21] = wwd(2'd1);
        instrMem[22] = {cpuPkg::opJmp, 12'd25};
        instrMem[23] = wwd(2'd0);
        instrMem[24] = wwd(2'd0);
        instrMem[25] = iType(cpuPkg::opAdi, 2'd1, 2'd1, 8'h01);
        instrMem[26] = wwd(2'd1);
        instrMem[27] = rType(2'd0, 2'd0, 2'd0, cpuPkg::funcHlt);

        expected[0] = 16'h1239;
        expected[1] = 16'h0004;
        expected[2] = 16'h1235;
        expected[3] = 16'h123A;
        expected[4] = 16'h1235;
        expected[5] = 16'h1236;
        expected[6] = 16'h1237;
    endtask

    // Every strobe must match the next expected value
    always @(negedge Clk) begin
        if (arstN && wwdStrobe) begin
            assert (strobeCount < numExpected && outputPort == expected[strobeCount])
                strobeCount++;
            else begin
                if (strobeCount >= numExpected) begin
                    $display("Unexpected extra WWD strobe at time %0t, outputPort %h",
                             $time, outputPort);
                end else begin
                    $display("MISMATCH at time %0t: outputPort expected %h got %h",
                             $time, expected[strobeCount], outputPort);
                end
                stopRun();
            end
        end
    end

    initial begin
        int cycles;
        void'($urandom(32'h6ee4_bc88));
        Clk = 1'b0;
        arstN = 1'b0;
        strobeCount = 0;
        loadProgram();
        repeat (3) @(negedge Clk);
        arstN = 1'b1;

        cycles = 0;
        while (!isHalted && cycles < haltTimeout) begin
            @(negedge Clk);
            cycles++;
        end
        assert (isHalted) else begin
            $display("Timeout: core did not halt within %0d cycles", haltTimeout);
            stopRun();
        end
        assert (numInst == expectedRetired) else begin
            $display("MISMATCH at time %0t: numInst expected %0d got %0d",
                     $time, expectedRetired, numInst);
            stopRun();
        end

        // Give any stray strobe time to show up
        cycles = 0;
        while (cycles < 10) begin
            @(negedge Clk);
            cycles++;
        end
        if (strobeCount == numExpected) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("MISMATCH at time %0t: strobe count expected %0d got %0d",
                     $time, numExpected, strobeCount);
            stopRun();
        end
    end

endmodule

`default_nettype wire

// ==== all.f ====
hdl/cpuPkg.sv
hdl/controlUnit.sv
hdl/registerFile.sv
hdl/alu.sv
hdl/hazardUnit.sv
hdl/datapath.sv
hdl/cpuTop.sv
testbench/cpu_checker.sv
testbench/cpuTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= cpuTb
BUILD_DIR ?= obj_dir
FILE_LIST ?= all.f
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0
FAIL_MSG ?= Test failures found
PASS_MSG ?= All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
